//--- sim.f
+incdir+.
corePkg.sv
instrDecoder.sv
regFile.sv
idExRegister.sv
executeStage.sv
decodeExecuteTop.sv
decodeExecute_properties.sv
decodeExecuteTb.sv

//--- run.sh
#!/bin/sh
# Builds the decode/execute testbench with Verilator, runs it and scans the log.
# A simulation that stops on its own (an assertion with $error) also counts as failing.

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module decodeExecuteTb -f sim.f \
    -o decodeExecuteSim \
    && ./obj_dir/decodeExecuteSim > sim.log 2>&1 \
    || echo "CHECKS FAILED" >> sim.log

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

//--- decodeExecuteTb.sv
module decodeExecuteTb;
    timeunit 1ns;
    timeprecision 100ps;
    import corePkg::*;

    localparam int ClkPeriod      = 8;
    localparam int InstrCount     = 90;
    localparam int TestCount      = 6;
    localparam int WatchdogCycles = 2 * (InstrCount + TestCount * 12) + 10;

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    // addi x30, x0, 0x123 sits behind every redirect and must never retire.
    localparam logic [31:0] shadowWord = {12'h123, 5'd0, 3'b000, 5'd30, opImm};

    logic        iClk;
    logic        arstN;
    logic        instrValid;
    instrWord    instr;
    logic [31:0] instrPc;
    logic        redirect;
    logic [31:0] redirectPc;
    retireBundle retire;

    logic [31:0] regModel [32];
    logic [31:0] expData [int];
    logic [4:0]  expRd [int];
    logic [31:0] expPc [int];
    logic [31:0] expTarget [int];
    logic [15:0] lfsr;
    logic [31:0] pc;
    int          cycle;
    int          errors;
    int          checks;

    decodeExecuteTop dut_i (
        .iClk       (iClk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .retire     (retire)
    );

    always #(ClkPeriod / 2) iClk = ~iClk;

    // ********************
    // encoders and LFSR
    // ********************

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // taps 16, 14, 13 and 11.
    function automatic logic lfsrBit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < count; i++) begin
            word = {word[30:0], lfsrBit()};
        end
        return word;
    endfunction

    // ********************
    // reference model
    // ********************

    function automatic logic [31:0] aluRef(input logic [3:0] sel, input logic [31:0] a,
                                           input logic [31:0] b);
        case (sel)
            4'b0000: return a + b;
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return {31'b0, $signed(a) < $signed(b)};
            4'b0011: return {31'b0, a < b};
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $unsigned($signed(a) >>> b[4:0]);
            4'b0110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic void predict(input logic [31:0] word, input logic [31:0] pcNow,
                                    output logic writes, output logic [31:0] value,
                                    output logic jumps, output logic [31:0] target);
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immB;
        logic [31:0] immJ;
        f3     = word[14:12];
        a      = regModel[word[19:15]];
        b      = regModel[word[24:20]];
        immI   = {{20{word[31]}}, word[31:20]};
        immB   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        immJ   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        writes = 1'b1;
        jumps  = 1'b0;
        value  = '0;
        target = '0;
        case (word[6:0])
            opReg:   value = aluRef({word[30], f3}, a, b);
            opImm:   value = aluRef({f3 == 3'b101 && word[30], f3}, a, immI);
            opLui:   value = {word[31:12], 12'b0};
            opAuipc: value = pcNow + {word[31:12], 12'b0};
            7'b1101111: begin
                value  = pcNow + 4;
                jumps  = 1'b1;
                target = pcNow + immJ;
            end
            opJalr: begin
                value  = pcNow + 4;
                jumps  = 1'b1;
                target = (a + immI) & ~32'd1;
            end
            7'b1100011: begin
                writes = 1'b0;
                jumps  = branchTaken(f3, a, b);
                target = pcNow + immB;
            end
            default: writes = 1'b0;
        endcase
        if (word[11:7] == 5'd0) begin
            writes = 1'b0;
        end
    endfunction

    // ********************
    // driving
    // ********************

    // presented at cycle n, a word redirects at n + 2 and retires at n + 3.
    task automatic issue(input logic [31:0] word);
        logic        writes;
        logic        jumps;
        logic [31:0] value;
        logic [31:0] target;
        predict(word, pc, writes, value, jumps, target);
        @(posedge iClk);
        instrValid <= 1'b1;
        instr      <= word;
        instrPc    <= pc;
        if (writes) begin
            regModel[word[11:7]] = value;
            expRd[cycle + 3]     = word[11:7];
            expData[cycle + 3]   = value;
            expPc[cycle + 3]     = pc;
        end
        if (jumps) begin
            expTarget[cycle + 2] = target;
            @(posedge iClk);
            instr   <= shadowWord;
            instrPc <= pc + 4;
            pc = target;
        end else begin
            pc = pc + 4;
        end
    endtask

    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'b0, value[11]};
        issue(uType(upper, rd, opLui));
        issue(iType(value[11:0], rd, 3'b000, rd, opImm));
    endtask

    task automatic drain();
        @(posedge iClk);
        instrValid <= 1'b0;
        while (expData.num() != 0 || expTarget.num() != 0) begin
            @(negedge iClk);
        end
        // the pipe is three cycles deep, so a stray retire shows up here.
        repeat (3) @(negedge iClk);
    endtask

    task automatic closeTest(input string name, input int errStart);
        if (errors == errStart) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errStart);
        end
    endtask

    // ********************
    // checker
    // ********************

    always @(negedge iClk) begin : retireChecker
        logic wantRetire;
        logic wantRedirect;
        cycle        = cycle + 1;
        wantRetire   = (expData.exists(cycle) != 0);
        wantRedirect = (expTarget.exists(cycle) != 0);
        if (arstN) begin
            checks = checks + 2;
            assert (retire.valid === wantRetire) else begin
                errors++;
                $display("ERROR retire.valid: expected %h, got %h at cycle %0d",
                         wantRetire, retire.valid, cycle);
            end
            assert (redirect === wantRedirect) else begin
                errors++;
                $display("ERROR redirect: expected %h, got %h at cycle %0d",
                         wantRedirect, redirect, cycle);
            end
            if (wantRetire && retire.valid) begin
                checks = checks + 3;
                assert (retire.rd === expRd[cycle]) else begin
                    errors++;
                    $display("ERROR retire.rd: expected %h, got %h", expRd[cycle], retire.rd);
                end
                assert (retire.data === expData[cycle]) else begin
                    errors++;
                    $display("ERROR retire.data: expected %h, got %h",
                             expData[cycle], retire.data);
                end
                assert (retire.pc === expPc[cycle]) else begin
                    errors++;
                    $display("ERROR retire.pc: expected %h, got %h",
                             expPc[cycle], retire.pc);
                end
            end
            if (wantRedirect && redirect) begin
                checks = checks + 1;
                assert (redirectPc === expTarget[cycle]) else begin
                    errors++;
                    $display("ERROR redirectPc: expected %h, got %h",
                             expTarget[cycle], redirectPc);
                end
            end
        end
        expData.delete(cycle);
        expRd.delete(cycle);
        expPc.delete(cycle);
        expTarget.delete(cycle);
    end

    // ********************
    // directed tests
    // ********************

    task automatic resetState();
        int errStart;
        errStart = errors;
        @(negedge iClk);
        checks = checks + 2;
        assert (retire.valid === 1'b0) else begin
            errors++;
            $display("ERROR retire.valid: expected 0, got %h after reset", retire.valid);
        end
        assert (redirect === 1'b0) else begin
            errors++;
            $display("ERROR redirect: expected 0, got %h after reset", redirect);
        end
        issue(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
        issue(rType(7'h00, 5'd31, 5'd17, 3'b110, 5'd6));
        drain();
        closeTest("reset state", errStart);
    endtask

    task automatic aluOperations();
        int          errStart;
        logic [31:0] bits;
        errStart = errors;
        loadReg(5'd1, randomBits(32));
        loadReg(5'd2, randomBits(32));
        loadReg(5'd3, randomBits(32));
        for (int f = 0; f < 8; f++) begin
            issue(rType(7'h00, 5'd2, 5'd1, f[2:0], 5'(10 + f)));
        end
        issue(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd18));
        issue(rType(7'h20, 5'd3, 5'd1, 3'b101, 5'd19));
        for (int f = 0; f < 8; f++) begin
            bits = randomBits(12);
            if (f == 1 || f == 5) begin
                bits = {27'b0, bits[4:0]};
            end
            issue(iType(bits[11:0], 5'd3, f[2:0], 5'(20 + f), opImm));
        end
        bits = randomBits(5);
        issue(iType({7'b0100000, bits[4:0]}, 5'd1, 3'b101, 5'd28, opImm));
        drain();
        closeTest("ALU operations", errStart);
    endtask

    task automatic forwardingPaths();
        int errStart;
        errStart = errors;
        loadReg(5'd8, randomBits(32));
        issue(rType(7'h00, 5'd8, 5'd8, 3'b000, 5'd9));
        issue(rType(7'h20, 5'd8, 5'd9, 3'b000, 5'd10));
        issue(rType(7'h00, 5'd10, 5'd9, 3'b100, 5'd11));
        issue(iType(randomBits(12), 5'd11, 3'b000, 5'd11, opImm));
        issue(rType(7'h00, 5'd11, 5'd8, 3'b111, 5'd12));
        drain();
        closeTest("forwarding", errStart);
    endtask

    task automatic branchResolution();
        int errStart;
        errStart = errors;
        loadReg(5'd1, randomBits(32));
        loadReg(5'd2, randomBits(32));
        issue(bType(13'd16, 5'd2, 5'd2, 3'b000));
        issue(bType(13'd16, 5'd1, 5'd1, 3'b001));
        for (int f = 4; f < 8; f++) begin
            issue(bType(13'd12, 5'd2, 5'd1, f[2:0]));
        end
        issue(bType(13'h1ff8, 5'd1, 5'd1, 3'b000));
        issue(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd13));
        drain();
        closeTest("branches", errStart);
    endtask

    task automatic jumpsAndUpper();
        int errStart;
        errStart = errors;
        issue(jType(21'd24, 5'd1));
        issue(iType(12'd8, 5'd1, 3'b000, 5'd5, opJalr));
        issue(uType(randomBits(20), 5'd6, opLui));
        issue(uType(randomBits(20), 5'd7, opAuipc));
        issue(jType(21'h1ffff0, 5'd14));
        // an odd target has its low bit cleared.
        issue(iType(12'hffd, 5'd7, 3'b000, 5'd15, opJalr));
        drain();
        closeTest("jumps and upper immediates", errStart);
    endtask

    task automatic zeroRegister();
        int errStart;
        errStart = errors;
        issue(iType(12'h055, 5'd1, 3'b000, 5'd0, opImm));
        issue(rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd16));
        issue(uType(20'habcde, 5'd0, opLui));
        issue(iType(12'h000, 5'd0, 3'b110, 5'd17, opImm));
        issue(jType(21'd8, 5'd0));
        issue(rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd18));
        drain();
        closeTest("x0 writes", errStart);
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        iClk       = 1'b0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        instrPc    = '0;
        lfsr       = 16'd81;
        pc         = 32'h0000_1000;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        repeat (2) @(posedge iClk);
        arstN <= 1'b1;
        resetState();
        aluOperations();
        forwardingPaths();
        branchResolution();
        jumpsAndUpper();
        zeroRegister();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- decodeExecute_properties.sv
module decodeExecuteProperties (
    input logic                 iClk,
    input logic                 arstN,
    input logic                 redirect,
    input corePkg::decodeBundle executeIn,
    input corePkg::retireBundle retire
);
    timeunit 1ns;
    timeprecision 100ps;

    // x0 writes are dropped in decode, so nothing retires to it.
    retireRdNonzero: assert property (@(posedge iClk) disable iff (!arstN)
        retire.valid |-> retire.rd != '0)
        else $error("a retire names rd zero");

    // the word behind a redirect enters execute as a bubble.
    flushedIsBubble: assert property (@(posedge iClk) disable iff (!arstN)
        redirect |=> !executeIn.valid)
        else $error("the instruction behind a redirect reached execute");

    flushedNeverRetires: assert property (@(posedge iClk) disable iff (!arstN)
        redirect |-> ##2 !retire.valid)
        else $error("the instruction behind a redirect retired");

    bubbleNoRedirect: assert property (@(posedge iClk) disable iff (!arstN)
        !executeIn.valid |-> !redirect)
        else $error("redirect raised while a bubble executes");

endmodule

bind decodeExecuteTop decodeExecuteProperties propsI (
    .iClk      (iClk),
    .arstN     (arstN),
    .redirect  (redirect),
    .executeIn (executeIn),
    .retire    (retire)
);

//--- decodeExecuteTop.sv
`include "core_defines.svh"

module decodeExecuteTop (
    input  logic                   iClk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  corePkg::instrWord      instr,
    input  logic [`DATA_WIDTH-1:0] instrPc,
    output logic                   redirect,
    output logic [`DATA_WIDTH-1:0] redirectPc,
    output corePkg::retireBundle   retire
);
    import corePkg::*;

    decodeBundle            decoded;
    decodeBundle            executeIn;
    logic [`DATA_WIDTH-1:0] rs1Data;
    logic [`DATA_WIDTH-1:0] rs2Data;

    // ********************
    // decode
    // ********************

    instrDecoder uDecoder (
        .instr   (instr),
        .instrPc (instrPc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .decoded (decoded)
    );

    // read addresses come straight from the instruction word, so the reads
    // run in parallel with the decoder.
    regFile uRegFile (
        .iClk      (iClk),
        .arstN     (arstN),
        .rs1       (instr.rFormat.rs1),
        .rs2       (instr.rFormat.rs2),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .writeBack (retire)
    );

    // ********************
    // execute
    // ********************

    idExRegister uIdEx (
        .iClk       (iClk),
        .arstN      (arstN),
        .flush      (redirect),
        .instrValid (instrValid),
        .decoded    (decoded),
        .executeIn  (executeIn)
    );

    executeStage uExecute (
        .iClk       (iClk),
        .arstN      (arstN),
        .executeIn  (executeIn),
        .flush      (redirect),
        .redirectPc (redirectPc),
        .retire     (retire)
    );

endmodule

//--- executeStage.sv
`include "core_defines.svh"

module executeStage (
    input  logic                   iClk,
    input  logic                   arstN,
    input  corePkg::decodeBundle   executeIn,
    output logic                   flush,
    output logic [`DATA_WIDTH-1:0] redirectPc,
    output corePkg::retireBundle   retire
);
    import corePkg::*;

    localparam int ShiftWidth = $clog2(`DATA_WIDTH);

    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluB;
    logic [ShiftWidth-1:0]  shamt;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] pcRelTarget;
    logic [`DATA_WIDTH-1:0] linkPc;
    logic [`DATA_WIDTH-1:0] result;
    logic                   condMet;

    // ********************
    // forwarding
    // ********************

    // a valid retire never carries rd zero, so x0 reads are left alone.
    assign opA = (retire.valid && retire.rd == executeIn.rs1) ? retire.data : executeIn.rs1Data;
    assign opB = (retire.valid && retire.rd == executeIn.rs2) ? retire.data : executeIn.rs2Data;

    // ********************
    // ALU and compare
    // ********************

    assign aluB  = executeIn.useImm ? executeIn.imm : opB;
    assign shamt = aluB[ShiftWidth-1:0];

    always_comb begin
        case (executeIn.aluCtrl)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluSll:  aluResult = opA << shamt;
            aluSlt:  aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(aluB)};
            aluSltu: aluResult = {{(`DATA_WIDTH-1){1'b0}}, opA < aluB};
            aluXor:  aluResult = opA ^ aluB;
            aluSrl:  aluResult = opA >> shamt;
            aluSra:  aluResult = $signed(opA) >>> shamt;
            aluOr:   aluResult = opA | aluB;
            aluAnd:  aluResult = opA & aluB;
            default: aluResult = opA + aluB;
        endcase
    end

    always_comb begin
        case (executeIn.brCond)
            brEq:    condMet = (opA == opB);
            brNe:    condMet = (opA != opB);
            brLt:    condMet = ($signed(opA) < $signed(opB));
            brGe:    condMet = ($signed(opA) >= $signed(opB));
            brLtu:   condMet = (opA < opB);
            brGeu:   condMet = (opA >= opB);
            default: condMet = 1'b0;
        endcase
    end

    // ********************
    // result and redirect
    // ********************

    assign pcRelTarget = executeIn.pc + executeIn.imm;
    assign linkPc      = executeIn.pc + `DATA_WIDTH'(4);

    always_comb begin
        result     = aluResult;
        flush      = 1'b0;
        redirectPc = pcRelTarget;
        case (executeIn.instrKind)
            clsLui:    result = executeIn.imm;
            clsAuipc:  result = pcRelTarget;
            clsJal: begin
                result = linkPc;
                flush  = 1'b1;
            end
            clsJalr: begin
                result     = linkPc;
                flush      = 1'b1;
                redirectPc = (opA + executeIn.imm) & ~`DATA_WIDTH'(1);
            end
            clsBranch: flush = condMet;
            default: begin
            end
        endcase
    end

    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            retire <= '0;
        end else begin
            retire.valid <= executeIn.valid && executeIn.regWrite;
            retire.rd    <= executeIn.rd;
            retire.data  <= result;
            retire.pc    <= executeIn.pc;
        end
    end

endmodule

//--- idExRegister.sv
module idExRegister (
    input  logic                 iClk,
    input  logic                 arstN,
    input  logic                 flush,
    input  logic                 instrValid,
    input  corePkg::decodeBundle decoded,
    output corePkg::decodeBundle executeIn
);
    import corePkg::*;

    // ********************
    // bubble
    // ********************

    localparam decodeBundle bubble = '{
        valid:     1'b0,
        instrKind: clsBubble,
        aluCtrl:   aluAdd,
        brCond:    brEq,
        useImm:    1'b0,
        regWrite:  1'b0,
        rs1:       '0,
        rs2:       '0,
        rd:        '0,
        rs1Data:   '0,
        rs2Data:   '0,
        imm:       '0,
        pc:        '0
    };

    // a flushed, absent or undecodable instruction enters execute as a bubble.
    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            executeIn <= bubble;
        end else if (flush || !instrValid || !decoded.valid) begin
            executeIn <= bubble;
        end else begin
            executeIn <= decoded;
        end
    end

endmodule

//--- regFile.sv
`include "core_defines.svh"

module regFile (
    input  logic                       iClk,
    input  logic                       arstN,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    output logic [`DATA_WIDTH-1:0]     rs1Data,
    output logic [`DATA_WIDTH-1:0]     rs2Data,
    input  corePkg::retireBundle       writeBack
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // entry zero is cleared by reset and never written afterwards.
    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeBack.valid && writeBack.rd != '0) begin
            regs[writeBack.rd] <= writeBack.data;
        end
    end

    // a read of the register being written this cycle returns the new value.
    assign rs1Data = (rs1 == '0) ? '0 :
                     (writeBack.valid && writeBack.rd == rs1) ? writeBack.data :
                     regs[rs1];

    assign rs2Data = (rs2 == '0) ? '0 :
                     (writeBack.valid && writeBack.rd == rs2) ? writeBack.data :
                     regs[rs2];

endmodule

//--- instrDecoder.sv
`include "core_defines.svh"

module instrDecoder (
    input  corePkg::instrWord      instr,
    input  logic [`DATA_WIDTH-1:0] instrPc,
    input  logic [`DATA_WIDTH-1:0] rs1Data,
    input  logic [`DATA_WIDTH-1:0] rs2Data,
    output corePkg::decodeBundle   decoded
);
    import corePkg::*;

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    logic [`DATA_WIDTH-1:0] immI;
    logic [`DATA_WIDTH-1:0] immB;
    logic [`DATA_WIDTH-1:0] immU;
    logic [`DATA_WIDTH-1:0] immJ;
    logic                   rLegal;
    logic                   immLegal;
    logic                   arithShift;

    // ********************
    // immediates
    // ********************

    assign immI = {{(`DATA_WIDTH-12){instr.iFormat.imm[11]}}, instr.iFormat.imm};
    assign immB = {{(`DATA_WIDTH-13){instr.bFormat.imm12}}, instr.bFormat.imm12,
                   instr.bFormat.imm11, instr.bFormat.imm10to5, instr.bFormat.imm4to1, 1'b0};
    assign immU = {instr.uFormat.imm31to12, 12'b0};
    assign immJ = {{(`DATA_WIDTH-21){instr.jFormat.imm20}}, instr.jFormat.imm20,
                   instr.jFormat.imm19to12, instr.jFormat.imm11, instr.jFormat.imm10to1, 1'b0};

    // funct7 only separates sub from add and sra from srl.
    assign rLegal = (instr.rFormat.funct7 == 7'b0000000) ||
                    (instr.rFormat.funct7 == 7'b0100000 &&
                     (instr.rFormat.funct3 == 3'b000 || instr.rFormat.funct3 == 3'b101));

    assign arithShift = (instr.iFormat.funct3 == 3'b101) && instr.iFormat.imm[10];

    // shift immediates carry a funct7 in imm[11:5].
    always_comb begin
        case (instr.iFormat.funct3)
            3'b001:  immLegal = (instr.iFormat.imm[11:5] == 7'b0000000);
            3'b101:  immLegal = ({instr.iFormat.imm[11], instr.iFormat.imm[9:5]} == 6'b0);
            default: immLegal = 1'b1;
        endcase
    end

    // ********************
    // control decode
    // ********************

    always_comb begin
        decoded           = '0;
        decoded.instrKind = clsBubble;
        decoded.aluCtrl   = aluAdd;
        decoded.brCond    = brEq;
        decoded.pc        = instrPc;
        case (instr.rFormat.opcode)
            opReg: begin
                if (rLegal) begin
                    decoded.instrKind = clsAluReg;
                    decoded.aluCtrl   = aluOp'({instr.rFormat.funct7[5], instr.rFormat.funct3});
                    decoded.rs1       = instr.rFormat.rs1;
                    decoded.rs2       = instr.rFormat.rs2;
                    decoded.rd        = instr.rFormat.rd;
                    decoded.rs1Data   = rs1Data;
                    decoded.rs2Data   = rs2Data;
                    decoded.regWrite  = 1'b1;
                end
            end
            opImm: begin
                if (immLegal) begin
                    decoded.instrKind = clsAluImm;
                    decoded.aluCtrl   = aluOp'({arithShift, instr.iFormat.funct3});
                    decoded.rs1       = instr.iFormat.rs1;
                    decoded.rd        = instr.iFormat.rd;
                    decoded.rs1Data   = rs1Data;
                    decoded.imm       = immI;
                    decoded.useImm    = 1'b1;
                    decoded.regWrite  = 1'b1;
                end
            end
            opLui, opAuipc: begin
                decoded.instrKind = (instr.uFormat.opcode == opLui) ? clsLui : clsAuipc;
                decoded.rd        = instr.uFormat.rd;
                decoded.imm       = immU;
                decoded.useImm    = 1'b1;
                decoded.regWrite  = 1'b1;
            end
            opJal: begin
                decoded.instrKind = clsJal;
                decoded.rd        = instr.jFormat.rd;
                decoded.imm       = immJ;
                decoded.regWrite  = 1'b1;
            end
            opJalr: begin
                if (instr.iFormat.funct3 == 3'b000) begin
                    decoded.instrKind = clsJalr;
                    decoded.rs1       = instr.iFormat.rs1;
                    decoded.rd        = instr.iFormat.rd;
                    decoded.rs1Data   = rs1Data;
                    decoded.imm       = immI;
                    decoded.regWrite  = 1'b1;
                end
            end
            opBranch: begin
                // funct3 values 010 and 011 are reserved for branches.
                if (instr.bFormat.funct3[2:1] != 2'b01) begin
                    decoded.instrKind = clsBranch;
                    decoded.brCond    = branchCond'(instr.bFormat.funct3);
                    decoded.rs1       = instr.bFormat.rs1;
                    decoded.rs2       = instr.bFormat.rs2;
                    decoded.rs1Data   = rs1Data;
                    decoded.rs2Data   = rs2Data;
                    decoded.imm       = immB;
                end
            end
            default: begin
            end
        endcase
        // x0 is never written, so rd need not be checked further down the pipe.
        if (decoded.rd == '0) begin
            decoded.regWrite = 1'b0;
        end
        decoded.valid = (decoded.instrKind != clsBubble);
    end

endmodule

//--- corePkg.sv
`include "core_defines.svh"

package corePkg;

    // ********************
    // instruction formats
    // ********************

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFields;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFields;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFields;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFields;

    // one instruction word, read through whichever view the opcode selects.
    typedef union packed {
        rFields rFormat;
        iFields iFormat;
        sFields sFormat;
        bFields bFormat;
        uFields uFormat;
        jFields jFormat;
    } instrWord;

    // ********************
    // control encodings
    // ********************

    typedef enum logic [2:0] {
        clsBubble = 3'd0,
        clsAluReg,
        clsAluImm,
        clsLui,
        clsAuipc,
        clsJal,
        clsJalr,
        clsBranch
    } instrClass;

    // the low three bits follow funct3, the top bit is funct7[5].
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOp;

    // encoded as the branch funct3.
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCond;

    // ********************
    // stage bundles
    // ********************

    typedef struct packed {
        logic                       valid;
        instrClass                  instrKind;
        aluOp                       aluCtrl;
        branchCond                  brCond;
        logic                       useImm;
        logic                       regWrite;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     rs1Data;
        logic [`DATA_WIDTH-1:0]     rs2Data;
        logic [`DATA_WIDTH-1:0]     imm;
        logic [`DATA_WIDTH-1:0]     pc;
    } decodeBundle;

    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     data;
        logic [`DATA_WIDTH-1:0]     pc;
    } retireBundle;

endpackage

//--- core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ********************
// datapath widths
// ********************

// width of a register and of every operand in the datapath.
`define DATA_WIDTH 32

// number of architectural registers, x0 included.
`define REG_COUNT 32

// width of a register index in the instruction word and in the bundles.
`define REG_ADDR_WIDTH 5

`endif
